// File: Bender.yml
package:
  name: dcache

sources:
  - hdl/dcachePkg.sv
  - hdl/replacementLogic.sv
  - hdl/tagStore.sv
  - hdl/dataStore.sv
  - hdl/cacheControl.sv
  - hdl/dcacheTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/dcacheTop_chk.sv
      - tests/dcacheTb.sv

// File: dcacheTop.f
hdl/dcachePkg.sv
hdl/replacementLogic.sv
hdl/tagStore.sv
hdl/dataStore.sv
hdl/cacheControl.sv
hdl/dcacheTop.sv
tests/clockGen.sv
tests/dcacheTop_chk.sv
tests/dcacheTb.sv

// File: hdl/cacheControl.sv
`timescale 1ns/10ps
`default_nettype none

module cacheControl import dcachePkg::*; #(
    parameter int setCount = 128
) (
    input  wire logic                                                clk,
    input  wire logic                                                resetn,
    input  wire cacheRequest                                         request,
    input  wire refillResponse                                       refillResp,
    output      cacheResponse                                        response,
    output      refillRequest                                        refill,
    output      logic                                                busy,
    output      logic [$clog2(setCount)-1:0]                         readIndex,
    output      logic [wordSelBits-1:0]                              readWordSel,
    input  wire logic [wayCount-1:0][31-$clog2(setCount)-lineOffsetBits:0] readTags,
    input  wire wayMask                                              readValid,
    input  wire wayAge [wayCount-1:0]                                readAges,
    input  wire cacheWord [wayCount-1:0]                             readWord,
    output      wayMask                                              hitMask,
    output      logic                                                isRefill,
    input  wire wayIndex                                             targetWay,
    input  wire wayAge [wayCount-1:0]                                newAges,
    output      logic                                                tagWrite,
    output      logic                                                dataWrite,
    output      logic [31-$clog2(setCount)-lineOffsetBits:0]         writeTag
);

    localparam int indexBits = $clog2(setCount);
    localparam int tagBits = 32 - indexBits - lineOffsetBits;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} ctrlState;

    ctrlState state;
    cacheAddr reqAddr;
    cacheWord respWord;
    cacheWord hitWord;
    logic     hit;
    logic     refillDone;

    assign busy = state != IDLE;
    assign writeTag = reqAddr[31 -: tagBits];
    assign readWordSel = reqAddr[lineOffsetBits-1 -: wordSelBits];

    // New requests look up their own set while the cache is idle.
    assign readIndex = (state == IDLE) ? request.addr[lineOffsetBits +: indexBits]
                                       : reqAddr[lineOffsetBits +: indexBits];

    always_comb begin
        hitWord = '0;
        for (int w = 0; w < wayCount; w++) begin
            hitMask[w] = readValid[w] && (readTags[w] == writeTag);
            if (hitMask[w]) begin
                hitWord = readWord[w];
            end
        end
    end

    assign hit = |hitMask;
    assign isRefill = (state == LOOKUP && !hit) || state == REFILL;
    assign refillDone = isRefill && refillResp.valid;
    assign tagWrite = (state == LOOKUP && hit) || refillDone;
    assign dataWrite = refillDone;

    assign refill.valid = isRefill;
    assign refill.lineAddr = {reqAddr[31:lineOffsetBits], {lineOffsetBits{1'b0}}};

    assign response.valid = (state == LOOKUP && hit) || state == RESPOND;
    assign response.data = (state == RESPOND) ? respWord : hitWord;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (request.valid) state <= LOOKUP;
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                    end else if (refillResp.valid) begin
                        state <= RESPOND;
                    end else begin
                        state <= REFILL;
                    end
                end
                REFILL:  if (refillResp.valid) state <= RESPOND;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && request.valid) begin
            reqAddr <= request.addr;
        end
        // Requested word is taken straight from the returned line.
        if (refillDone) begin
            respWord <= refillResp.line[readWordSel];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dataStore.sv
`timescale 1ns/10ps
`default_nettype none

module dataStore import dcachePkg::*; #(
    parameter int setCount = 128
) (
    input  wire logic                          clk,
    input  wire logic [$clog2(setCount)-1:0]   readIndex,
    input  wire logic [wordSelBits-1:0]        readWordSel,
    output      cacheWord [wayCount-1:0]       readWord,
    input  wire logic                          dataWrite,
    input  wire wayIndex                       writeWay,
    input  wire cacheLine                      writeLine
);

    cacheLine [wayCount-1:0] lineArray [setCount];
    cacheLine [wayCount-1:0] readLines;

    // All ways of the set are read at once.
    always_ff @(posedge clk) begin
        readLines <= lineArray[readIndex];
        if (dataWrite) begin
            lineArray[readIndex][writeWay] <= writeLine;
        end
    end

    always_comb begin
        for (int w = 0; w < wayCount; w++) begin
            readWord[w] = readLines[w][readWordSel];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcachePkg.sv
`default_nettype none

package dcachePkg;

    // Fixed geometry.
    localparam int wayCount = 4;
    localparam int lineWords = 8;
    localparam int lineOffsetBits = 5;
    localparam int wordSelBits = 3;

    typedef logic [31:0] cacheWord;
    typedef cacheWord [lineWords-1:0] cacheLine;
    typedef logic [31:0] cacheAddr;
    typedef logic [1:0] wayIndex;

    // Age 0 is the most recent way.
    typedef logic [1:0] wayAge;
    typedef logic [wayCount-1:0] wayMask;

    typedef struct packed {
        logic     valid;
        cacheAddr addr;
    } cacheRequest;

    typedef struct packed {
        logic     valid;
        cacheWord data;
    } cacheResponse;

    typedef struct packed {
        logic     valid;
        cacheAddr lineAddr;
    } refillRequest;

    typedef struct packed {
        logic     valid;
        cacheLine line;
    } refillResponse;

endpackage

`default_nettype wire

// File: hdl/dcacheTop.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTop import dcachePkg::*; #(
    parameter int setCount = 128
) (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire cacheRequest   request,
    output      cacheResponse  response,
    output      refillRequest  refill,
    input  wire refillResponse refillResp,
    output      logic          busy
);

    localparam int indexBits = $clog2(setCount);
    localparam int tagBits = 32 - indexBits - lineOffsetBits;

    logic [indexBits-1:0]                readIndex;
    logic [wordSelBits-1:0]              readWordSel;
    logic [wayCount-1:0][tagBits-1:0]    readTags;
    wayMask                              readValid;
    wayAge [wayCount-1:0]                readAges;
    cacheWord [wayCount-1:0]             readWord;
    wayMask                              hitMask;
    logic                                isRefill;
    wayIndex                             targetWay;
    wayAge [wayCount-1:0]                newAges;
    logic                                tagWrite;
    logic                                dataWrite;
    logic [tagBits-1:0]                  writeTag;

    cacheControl #(.setCount(setCount)) controlInst (
        .clk         (clk),
        .resetn      (resetn),
        .request     (request),
        .refillResp  (refillResp),
        .response    (response),
        .refill      (refill),
        .busy        (busy),
        .readIndex   (readIndex),
        .readWordSel (readWordSel),
        .readTags    (readTags),
        .readValid   (readValid),
        .readAges    (readAges),
        .readWord    (readWord),
        .hitMask     (hitMask),
        .isRefill    (isRefill),
        .targetWay   (targetWay),
        .newAges     (newAges),
        .tagWrite    (tagWrite),
        .dataWrite   (dataWrite),
        .writeTag    (writeTag)
    );

    tagStore #(.setCount(setCount)) tagInst (
        .clk       (clk),
        .resetn    (resetn),
        .readIndex (readIndex),
        .readTags  (readTags),
        .readValid (readValid),
        .readAges  (readAges),
        .tagWrite  (tagWrite),
        .isRefill  (isRefill),
        .writeWay  (targetWay),
        .writeTag  (writeTag),
        .newAges   (newAges)
    );

    replacementLogic replacementInst (
        .hitMask   (hitMask),
        .readValid (readValid),
        .readAges  (readAges),
        .isRefill  (isRefill),
        .targetWay (targetWay),
        .newAges   (newAges)
    );

    dataStore #(.setCount(setCount)) dataInst (
        .clk         (clk),
        .readIndex   (readIndex),
        .readWordSel (readWordSel),
        .readWord    (readWord),
        .dataWrite   (dataWrite),
        .writeWay    (targetWay),
        .writeLine   (refillResp.line)
    );

endmodule

`default_nettype wire

// File: hdl/replacementLogic.sv
`timescale 1ns/10ps
`default_nettype none

module replacementLogic import dcachePkg::*; (
    input  wire wayMask               hitMask,
    input  wire wayMask               readValid,
    input  wire wayAge [wayCount-1:0] readAges,
    input  wire logic                 isRefill,
    output      wayIndex              targetWay,
    output      wayAge [wayCount-1:0] newAges
);

    wayIndex hitWay;
    wayIndex victimWay;
    logic    victimFound;
    wayAge   oldAge;

    always_comb begin
        hitWay = '0;
        victimWay = '0;
        victimFound = 1'b0;
        for (int w = wayCount - 1; w >= 0; w--) begin
            if (hitMask[w]) begin
                hitWay = wayIndex'(w);
            end
        end
        // An empty way wins before the oldest one.
        for (int w = wayCount - 1; w >= 0; w--) begin
            if (!readValid[w]) begin
                victimWay = wayIndex'(w);
                victimFound = 1'b1;
            end
        end
        if (!victimFound) begin
            for (int w = wayCount - 1; w >= 0; w--) begin
                if (readAges[w] == 2'd3) begin
                    victimWay = wayIndex'(w);
                end
            end
        end
    end

    assign targetWay = isRefill ? victimWay : hitWay;
    assign oldAge = readAges[targetWay];

    // Ways younger than the target age by one step.
    always_comb begin
        for (int w = 0; w < wayCount; w++) begin
            if (wayIndex'(w) == targetWay) begin
                newAges[w] = 2'd0;
            end else if (readAges[w] < oldAge) begin
                newAges[w] = readAges[w] + 2'd1;
            end else begin
                newAges[w] = readAges[w];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tagStore.sv
`timescale 1ns/10ps
`default_nettype none

module tagStore import dcachePkg::*; #(
    parameter int setCount = 128
) (
    input  wire logic                                                clk,
    input  wire logic                                                resetn,
    input  wire logic [$clog2(setCount)-1:0]                         readIndex,
    output      logic [wayCount-1:0][31-$clog2(setCount)-lineOffsetBits:0] readTags,
    output      wayMask                                              readValid,
    output      wayAge [wayCount-1:0]                                readAges,
    input  wire logic                                                tagWrite,
    input  wire logic                                                isRefill,
    input  wire wayIndex                                             writeWay,
    input  wire logic [31-$clog2(setCount)-lineOffsetBits:0]         writeTag,
    input  wire wayAge [wayCount-1:0]                                newAges
);

    localparam int indexBits = $clog2(setCount);
    localparam int tagBits = 32 - indexBits - lineOffsetBits;

    logic [wayCount-1:0][tagBits-1:0] tagArray [setCount];
    wayMask                           validArray [setCount];
    wayAge [wayCount-1:0]             ageArray [setCount];

    // After reset no way is valid and every age is the oldest.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < setCount; s++) begin
                validArray[s] <= '0;
                ageArray[s] <= {wayCount{2'd3}};
            end
        end else if (tagWrite) begin
            ageArray[readIndex] <= newAges;
            if (isRefill) begin
                validArray[readIndex][writeWay] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tagWrite && isRefill) begin
            tagArray[readIndex][writeWay] <= writeTag;
        end
    end

    // Write index equals the latched read index, so one address serves both.
    always_ff @(posedge clk) begin
        readTags <= tagArray[readIndex];
        readValid <= validArray[readIndex];
        readAges <= ageArray[readIndex];
    end

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int periodNs = 40,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset is released on a rising edge.
    initial begin
        resetn = 1'b0;
        repeat (resetCycles) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/dcacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTb import dcachePkg::*; ();

    localparam int setCount = 128;
    localparam int indexBits = $clog2(setCount);
    localparam int tagBits = 32 - indexBits - lineOffsetBits;
    localparam int randomCount = 300;
    // Upper bound on the directed accesses.
    localparam int directedCount = 30;
    localparam int watchdogCycles = (directedCount + randomCount) * 20 + 2000;

    logic          clk;
    logic          resetn;
    cacheRequest   request;
    cacheResponse  response;
    refillRequest  refill;
    refillResponse refillResp;
    logic          busy;

    logic [31:0]        lfsrState;
    logic [tagBits-1:0] modelTag [setCount][wayCount];
    logic               modelValid [setCount][wayCount];
    int                 modelAge [setCount][wayCount];

    clockGen #(.periodNs(40), .resetCycles(8)) clockInst (.clk(clk), .resetn(resetn));

    dcacheTop #(.setCount(setCount)) DUT (
        .clk        (clk),
        .resetn     (resetn),
        .request    (request),
        .response   (response),
        .refill     (refill),
        .refillResp (refillResp),
        .busy       (busy)
    );

    function automatic int randomBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    // Memory contents: word k of line L is (L + 4k) xor A5A50000.
    function automatic cacheWord memWord(input cacheAddr lineAddr, input int k);
        return (lineAddr + cacheAddr'(4 * k)) ^ 32'hA5A5_0000;
    endfunction

    function automatic cacheLine memLine(input cacheAddr lineAddr);
        cacheLine line;
        for (int k = 0; k < lineWords; k++) begin
            line[k] = memWord(lineAddr, k);
        end
        return line;
    endfunction

    function automatic cacheAddr makeAddr(input int tag, input int set, input int word);
        cacheAddr addr;
        addr = '0;
        addr[31 -: tagBits] = tag[tagBits-1:0];
        addr[lineOffsetBits +: indexBits] = set[indexBits-1:0];
        addr[lineOffsetBits-1 -: wordSelBits] = word[wordSelBits-1:0];
        return addr;
    endfunction

    // Reference cache: hit check and age update per the replacement rule.
    function automatic logic modelAccess(input cacheAddr addr);
        int                 set;
        int                 way;
        int                 oldAge;
        logic               hit;
        logic [tagBits-1:0] tag;
        set = addr[lineOffsetBits +: indexBits];
        tag = addr[31 -: tagBits];
        hit = 1'b0;
        way = -1;
        for (int w = 0; w < wayCount; w++) begin
            if (modelValid[set][w] && modelTag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = wayCount - 1; w >= 0; w--) begin
                if (!modelValid[set][w]) way = w;
            end
            if (way < 0) begin
                for (int w = wayCount - 1; w >= 0; w--) begin
                    if (modelAge[set][w] == 3) way = w;
                end
            end
            modelValid[set][way] = 1'b1;
            modelTag[set][way] = tag;
        end
        oldAge = modelAge[set][way];
        for (int w = 0; w < wayCount; w++) begin
            if (w != way && modelAge[set][w] < oldAge) modelAge[set][w]++;
        end
        modelAge[set][way] = 0;
        return hit;
    endfunction

    task automatic failRun(input string message);
        $display("%s", message);
        $display("Errors found");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic checkWord(input cacheWord got, input cacheWord want);
        if (got !== want) begin
            failRun($sformatf("Mismatch at %0t ns: response word %h, expected %h",
                              $time, got, want));
        end
    endtask

    task automatic checkLineAddr(input cacheAddr got, input cacheAddr want);
        if (got !== want) begin
            failRun($sformatf("Mismatch at %0t ns: refill line address %h, expected %h",
                              $time, got, want));
        end
    endtask

    task automatic checkFlag(input logic got, input logic want, input string what);
        if (got !== want) begin
            failRun($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                              $time, what, got, want));
        end
    endtask

    // One request from presentation to response, serving any refill on the way.
    task automatic runAccess(input cacheAddr addr, output logic wasHit);
        logic     expHit;
        logic     lastRefill;
        logic     lineReturned;
        logic     giveLine;
        logic     done;
        cacheAddr expLine;
        cacheAddr sampledLine;
        cacheWord expWord;
        int       cycles;
        int       refillRises;
        int       delay;
        expHit = modelAccess(addr);
        expLine = {addr[31:lineOffsetBits], {lineOffsetBits{1'b0}}};
        expWord = memWord(expLine, int'(addr[lineOffsetBits-1 -: wordSelBits]));
        cycles = 0;
        refillRises = 0;
        delay = 0;
        lastRefill = 1'b0;
        lineReturned = 1'b0;
        done = 1'b0;
        sampledLine = '0;
        @(posedge clk);
        request.valid <= 1'b1;
        request.addr <= addr;
        @(negedge clk);
        if (busy) failRun("The cache was still busy when a new request was presented.");
        @(posedge clk);
        request.valid <= 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            giveLine = 1'b0;
            checkFlag(busy, 1'b1, "busy while a request is in flight");
            if (refill.valid) begin
                checkLineAddr(refill.lineAddr, expLine);
                sampledLine = refill.lineAddr;
                if (!lastRefill) begin
                    refillRises++;
                    delay = randomBits(3);
                end
                if (!refillResp.valid) begin
                    if (delay == 0) giveLine = 1'b1;
                    else delay--;
                end
            end
            lastRefill = refill.valid;
            if (response.valid) begin
                done = 1'b1;
                checkWord(response.data, expWord);
                if (refillRises == 0 && cycles != 1) begin
                    failRun($sformatf("A hit answered %0d cycles after acceptance.", cycles));
                end
                if (refillRises == 1 && !lineReturned) begin
                    failRun("A refilled request did not answer right after the returned line.");
                end
                if (refillRises > 1) failRun("One request made more than one refill.");
            end
            lineReturned = refillResp.valid;
            @(posedge clk);
            refillResp.valid <= giveLine;
            refillResp.line <= giveLine ? memLine(sampledLine) : '0;
        end
        wasHit = (refillRises == 0);
        checkFlag(wasHit, expHit, "hit against the reference model");
    endtask

    task automatic expectAccess(input cacheAddr addr, input logic want, input string what);
        logic hit;
        runAccess(addr, hit);
        checkFlag(hit, want, what);
    endtask

    task automatic testResetState();
        checkFlag(busy, 1'b0, "busy after reset");
        checkFlag(response.valid, 1'b0, "response.valid after reset");
        checkFlag(refill.valid, 1'b0, "refill.valid after reset");
    endtask

    task automatic testFirstAndRepeat();
        expectAccess(makeAddr(1, 3, 5), 1'b0, "hit on first access");
        expectAccess(makeAddr(1, 3, 2), 1'b1, "hit on repeat access");
    endtask

    task automatic testFillSet();
        for (int t = 1; t <= 5; t++) begin
            expectAccess(makeAddr(t, 10, t), 1'b0, "hit while filling the set");
        end
        expectAccess(makeAddr(1, 10, 7), 1'b0, "hit on the evicted first tag");
        expectAccess(makeAddr(5, 10, 0), 1'b1, "hit on the fifth tag");
    endtask

    // Touching the first tag makes the second one the oldest.
    task automatic testAgeRefresh();
        for (int t = 1; t <= 4; t++) begin
            expectAccess(makeAddr(t, 20, 0), 1'b0, "hit while filling the set");
        end
        expectAccess(makeAddr(1, 20, 1), 1'b1, "hit on the first tag");
        expectAccess(makeAddr(5, 20, 2), 1'b0, "hit on the new tag");
        expectAccess(makeAddr(1, 20, 3), 1'b1, "hit on the refreshed first tag");
        expectAccess(makeAddr(4, 20, 4), 1'b1, "hit on the fourth tag");
        expectAccess(makeAddr(2, 20, 5), 1'b0, "hit on the evicted second tag");
    endtask

    task automatic testRandomRun();
        logic hit;
        int   tag;
        int   set;
        int   word;
        for (int i = 0; i < randomCount; i++) begin
            tag = 100 + randomBits(3);
            set = 40 + randomBits(2);
            word = randomBits(3);
            runAccess(makeAddr(tag, set, word), hit);
        end
    endtask

    initial begin
        request = '0;
        refillResp = '0;
        lfsrState = 32'h71472978;
        for (int s = 0; s < setCount; s++) begin
            for (int w = 0; w < wayCount; w++) begin
                modelValid[s][w] = 1'b0;
                modelAge[s][w] = 3;
                modelTag[s][w] = '0;
            end
        end
        while (resetn !== 1'b1) @(negedge clk);
        testResetState();
        testFirstAndRepeat();
        testFillSet();
        testAgeRefresh();
        testRandomRun();
        repeat (2) @(posedge clk);
        if (DUT.handshakeChk.failures == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Handshake assertions failed during the run.");
            $display("Errors found");
            $fatal(1, "Run ended with assertion failures.");
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("The tests did not finish within %0d cycles.", watchdogCycles);
        $display("Errors found");
        $fatal(1, "Watchdog timeout.");
    end

endmodule

`default_nettype wire

// File: tests/dcacheTop_chk.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTopChk import dcachePkg::*; (
    input wire logic          clk,
    input wire logic          resetn,
    input wire cacheResponse  response,
    input wire refillRequest  refill,
    input wire refillResponse refillResp,
    input wire logic          busy
);

    int failures = 0;

    // One response cycle per request.
    singleResponse: assert property (@(posedge clk) disable iff (!resetn)
        response.valid |=> !response.valid)
        else begin
            failures++;
            $error("response.valid was high for two cycles in a row");
        end

    stableLineAddr: assert property (@(posedge clk) disable iff (!resetn)
        refill.valid && !refillResp.valid |=> refill.valid && $stable(refill.lineAddr))
        else begin
            failures++;
            $error("refill request changed before the line was returned");
        end

    busyDuringRefill: assert property (@(posedge clk) disable iff (!resetn)
        refill.valid |-> busy)
        else begin
            failures++;
            $error("refill.valid high while busy is low");
        end

endmodule

bind dcacheTop dcacheTopChk handshakeChk (
    .clk        (clk),
    .resetn     (resetn),
    .response   (response),
    .refill     (refill),
    .refillResp (refillResp),
    .busy       (busy)
);

`default_nettype wire
